//--- filelist.f
+incdir+common
common/dual_issue_pkg.sv
common/lane_if.sv
hw/issue_steer.sv
exec_lane/lane_alu.sv
exec_lane/exec_lane.sv
hw/register_file.sv
hw/dual_issue_core.sv
dv/wb_checker.sv
dv/tb_dual_issue.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dual-issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_dual_issue \
  --Mdir obj_dir -o tb_dual_issue
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dual_issue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0

//--- dv/tb_dual_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module tb_dual_issue;

  localparam int MAX_ROWS    = 32;
  localparam int HOLD_LIMIT  = 8;
  localparam int DRAIN_LIMIT = 64;

  logic                      clk;
  logic                      arst_n;
  logic                      instr_valid;
  logic [31:0]               instr0;
  logic [31:0]               instr1;
  logic                      fetch_stall;
  logic                      wb_en0;
  logic [`DI_REG_ADDR_W-1:0] wb_addr0;
  logic [`DI_DATA_WIDTH-1:0] wb_data0;
  logic                      wb_en1;
  logic [`DI_REG_ADDR_W-1:0] wb_addr1;
  logic [`DI_DATA_WIDTH-1:0] wb_data1;
  logic [127:0]              cur_name;
  logic                      checks_done;
  int                        value_errors;
  int                        other_errors;
  int                        timeouts;

  // stimulus table
  logic [127:0] tbl_name [MAX_ROWS];
  logic [31:0]  tbl_i0 [MAX_ROWS];
  logic [31:0]  tbl_i1 [MAX_ROWS];
  logic         tbl_rnd [MAX_ROWS];
  int           n_rows;
  logic [5:0]   kept_ops [8];
  logic [31:0]  lfsr;

  dual_issue_core UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr0      (instr0),
    .instr1      (instr1),
    .fetch_stall (fetch_stall),
    .wb_en0      (wb_en0),
    .wb_addr0    (wb_addr0),
    .wb_data0    (wb_data0),
    .wb_en1      (wb_en1),
    .wb_addr1    (wb_addr1),
    .wb_data1    (wb_data1)
  );

  wb_checker u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr0       (instr0),
    .instr1       (instr1),
    .fetch_stall  (fetch_stall),
    .wb_en0       (wb_en0),
    .wb_addr0     (wb_addr0),
    .wb_data0     (wb_data0),
    .wb_en1       (wb_en1),
    .wb_addr1     (wb_addr1),
    .wb_data1     (wb_data1),
    .row_name     (cur_name),
    .done         (checks_done),
    .value_errors (value_errors),
    .other_errors (other_errors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] r_op(dual_issue_pkg::opcode_e op, int rd, int rs, int rt);
    return {op, rs[4:0], rt[4:0], rd[4:0], 11'h000};
  endfunction

  function automatic logic [31:0] i_op(dual_issue_pkg::opcode_e op, int rt, int rs, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  //////////////////////////////
  // random fields
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic rand_instr(output logic [31:0] ins);
    logic [31:0] sel;
    logic [31:0] regs;
    logic [31:0] low;
    take_bits(3, sel);
    take_bits(10, regs);
    take_bits(16, low);
    ins = {kept_ops[sel[2:0]], regs[9:0], low[15:0]};
  endtask

  task automatic add_row(input logic [127:0] name, input logic [31:0] i0,
                         input logic [31:0] i1, input logic rnd);
    tbl_name[n_rows] = name;
    tbl_i0[n_rows] = i0;
    tbl_i1[n_rows] = i1;
    tbl_rnd[n_rows] = rnd;
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    kept_ops[0] = dual_issue_pkg::ADD;
    kept_ops[1] = dual_issue_pkg::SUB;
    kept_ops[2] = dual_issue_pkg::AND;
    kept_ops[3] = dual_issue_pkg::OR;
    kept_ops[4] = dual_issue_pkg::XOR;
    kept_ops[5] = dual_issue_pkg::SLT;
    kept_ops[6] = dual_issue_pkg::ADDI;
    kept_ops[7] = dual_issue_pkg::ORI;
    add_row("imm_pair", i_op(dual_issue_pkg::ADDI, 1, 0, 'h8001),
            i_op(dual_issue_pkg::ORI, 2, 0, 'hbeef), 1'b0);
    add_row("imm_pair2", i_op(dual_issue_pkg::ADDI, 3, 0, 5),
            i_op(dual_issue_pkg::ORI, 4, 0, 'hffff), 1'b0);
    // r5 goes negative
    add_row("load_neg", r_op(dual_issue_pkg::SUB, 5, 0, 1),
            i_op(dual_issue_pkg::ADDI, 6, 0, 7), 1'b0);
    add_row("add_sub", r_op(dual_issue_pkg::ADD, 7, 1, 3),
            r_op(dual_issue_pkg::SUB, 8, 4, 2), 1'b0);
    add_row("and_or", r_op(dual_issue_pkg::AND, 9, 4, 2),
            r_op(dual_issue_pkg::OR, 10, 1, 3), 1'b0);
    add_row("xor_slt", r_op(dual_issue_pkg::XOR, 11, 2, 4),
            r_op(dual_issue_pkg::SLT, 12, 5, 6), 1'b0);
    add_row("slt_rev", r_op(dual_issue_pkg::SLT, 13, 6, 5),
            r_op(dual_issue_pkg::SLT, 14, 1, 5), 1'b0);
    add_row("dep_rs", i_op(dual_issue_pkg::ADDI, 15, 3, 'h10),
            r_op(dual_issue_pkg::ADD, 16, 15, 1), 1'b0);
    add_row("dep_rt", r_op(dual_issue_pkg::OR, 17, 2, 1),
            r_op(dual_issue_pkg::SUB, 18, 6, 17), 1'b0);
    add_row("fwd_a", r_op(dual_issue_pkg::ADD, 19, 1, 2),
            r_op(dual_issue_pkg::XOR, 20, 3, 4), 1'b0);
    add_row("fwd_b", r_op(dual_issue_pkg::ADD, 21, 20, 0),
            r_op(dual_issue_pkg::SUB, 22, 19, 20), 1'b0);
    add_row("same_dest", i_op(dual_issue_pkg::ADDI, 23, 0, 'h11),
            i_op(dual_issue_pkg::ORI, 23, 0, 'h22), 1'b0);
    add_row("read_same", r_op(dual_issue_pkg::ADD, 24, 23, 0),
            i_op(dual_issue_pkg::ADDI, 25, 23, 1), 1'b0);
    // r0 is never a dependency
    add_row("r0_write", i_op(dual_issue_pkg::ADDI, 0, 1, 5),
            r_op(dual_issue_pkg::ADD, 0, 0, 3), 1'b0);
    // r23 comes back from storage by now
    add_row("r0_read", r_op(dual_issue_pkg::ADD, 26, 0, 1),
            r_op(dual_issue_pkg::ADD, 27, 23, 0), 1'b0);
    for (int k = 0; k < 8; k++) begin
      add_row("random", 32'h0, 32'h0, 1'b1);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int          hold;
    int          quiet;
    int          waited;
    logic        accepted;
    logic [31:0] ins_a;
    logic [31:0] ins_b;
    arst_n = 1'b0;
    instr_valid = 1'b0;
    instr0 = 32'h0;
    instr1 = 32'h0;
    cur_name = "reset";
    checks_done = 1'b0;
    timeouts = 0;
    lfsr = 32'h9cb3;
    build_table();
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    for (int r = 0; r < n_rows; r++) begin
      ins_a = tbl_i0[r];
      ins_b = tbl_i1[r];
      if (tbl_rnd[r]) begin
        rand_instr(ins_a);
        rand_instr(ins_b);
      end
      @(negedge clk);
      instr_valid = 1'b1;
      instr0 = ins_a;
      instr1 = ins_b;
      cur_name = tbl_name[r];
      // hold the pair through a split
      accepted = 1'b0;
      hold = 0;
      while (!accepted && hold < HOLD_LIMIT) begin
        @(posedge clk);
        accepted = !fetch_stall;
        hold++;
      end
      if (!accepted) begin
        $display("timeout: row %0s was never accepted", tbl_name[r]);
        timeouts++;
      end
    end

    @(negedge clk);
    instr_valid = 1'b0;
    quiet = 0;
    waited = 0;
    while (quiet < 4 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      quiet = (!wb_en0 && !wb_en1) ? quiet + 1 : 0;
      waited++;
    end
    if (quiet < 4) begin
      $display("timeout: write-backs did not drain");
      timeouts++;
    end

    @(negedge clk);
    checks_done = 1'b1;
    repeat (2) @(negedge clk);
    $display("errors: %0d value, %0d other, %0d timeout", value_errors, other_errors, timeouts);
    if (value_errors + other_errors + timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/wb_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module wb_checker (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      instr_valid,
  input  logic [31:0]               instr0,
  input  logic [31:0]               instr1,
  input  logic                      fetch_stall,
  input  logic                      wb_en0,
  input  logic [`DI_REG_ADDR_W-1:0] wb_addr0,
  input  logic [`DI_DATA_WIDTH-1:0] wb_data0,
  input  logic                      wb_en1,
  input  logic [`DI_REG_ADDR_W-1:0] wb_addr1,
  input  logic [`DI_DATA_WIDTH-1:0] wb_data1,
  input  logic [127:0]              row_name,
  input  logic                      done,
  output int                        value_errors,
  output int                        other_errors
);

  logic [`DI_DATA_WIDTH-1:0] model [`DI_NUM_REGS];
  logic [`DI_REG_ADDR_W-1:0] exp_addr [$];
  logic [`DI_DATA_WIDTH-1:0] exp_data [$];
  int                        exp_due [$];
  logic [127:0]              exp_name [$];
  int                        cycle = 0;
  int                        n_value = 0;
  int                        n_other = 0;
  logic                      split = 1'b0;
  logic                      done_seen = 1'b0;
  logic                      exp_stall;

  assign value_errors = n_value;
  assign other_errors = n_other;

  //////////////////////////////
  // reference instruction rules
  //////////////////////////////

  function automatic logic is_r(logic [31:0] ins);
    case (ins[31:26])
      dual_issue_pkg::ADD, dual_issue_pkg::SUB, dual_issue_pkg::AND,
      dual_issue_pkg::OR, dual_issue_pkg::XOR, dual_issue_pkg::SLT: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic is_i(logic [31:0] ins);
    return (ins[31:26] == dual_issue_pkg::ADDI) || (ins[31:26] == dual_issue_pkg::ORI);
  endfunction

  // zero means no write
  function automatic logic [4:0] dest_of(logic [31:0] ins);
    return is_r(ins) ? ins[15:11] : (is_i(ins) ? ins[20:16] : 5'd0);
  endfunction

  // second instruction reads what the first one writes
  function automatic logic splits(logic [31:0] i0, logic [31:0] i1);
    logic [4:0] d;
    d = dest_of(i0);
    return (d != 5'd0) &&
           (((is_r(i1) || is_i(i1)) && (i1[25:21] == d)) || (is_r(i1) && (i1[20:16] == d)));
  endfunction

  function automatic logic [31:0] result_of(logic [31:0] ins, logic [31:0] a, logic [31:0] b);
    logic [31:0] imm;
    imm = {16'h0000, ins[15:0]};
    case (ins[31:26])
      dual_issue_pkg::ADD:  return a + b;
      dual_issue_pkg::SUB:  return a - b;
      dual_issue_pkg::AND:  return a & b;
      dual_issue_pkg::OR:   return a | b;
      dual_issue_pkg::XOR:  return a ^ b;
      dual_issue_pkg::SLT:  return {31'd0, $signed(a) < $signed(b)};
      dual_issue_pkg::ADDI: return a + imm;
      dual_issue_pkg::ORI:  return a | imm;
      default:              return 32'd0;
    endcase
  endfunction

  task automatic run_instr(input logic [31:0] ins, input int due);
    logic [4:0]  d;
    logic [31:0] v;
    d = dest_of(ins);
    v = result_of(ins, model[ins[25:21]], model[ins[20:16]]);
    if (d != 5'd0) begin
      model[d] = v;
      exp_addr.push_back(d);
      exp_data.push_back(v);
      exp_due.push_back(due);
      exp_name.push_back(row_name);
    end
  endtask

  task automatic check_lane(input int lane, input logic en, input logic [4:0] addr,
                            input logic [31:0] data);
    if (en) begin
      if (exp_addr.size() == 0) begin
        $display("lane %0d wrote r%0d in cycle %0d with no write expected", lane, addr, cycle);
        n_other++;
      end else begin
        if (exp_due[0] != cycle) begin
          $display("write-back for %0s came in cycle %0d, due in cycle %0d",
                   exp_name[0], cycle, exp_due[0]);
          n_other++;
        end
        if ((addr !== exp_addr[0]) || (data !== exp_data[0])) begin
          $display("FAILED %0s: lane %0d expected r%0d=%h, actual r%0d=%h",
                   exp_name[0], lane, exp_addr[0], exp_data[0], addr, data);
          n_value++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_due.pop_front());
        void'(exp_name.pop_front());
      end
    end
  endtask

  //////////////////////////////
  // per-cycle comparison
  //////////////////////////////

  always @(posedge clk) begin
    if (!arst_n) begin
      if (fetch_stall || wb_en0 || wb_en1) begin
        $display("FAILED reset: expected stall/wb_en 000, actual %b%b%b",
                 fetch_stall, wb_en0, wb_en1);
        n_value++;
      end
      for (int r = 0; r < `DI_NUM_REGS; r++) begin
        model[r] = '0;
      end
      split = 1'b0;
    end else begin
      // older lane first
      check_lane(0, wb_en0, wb_addr0, wb_data0);
      check_lane(1, wb_en1, wb_addr1, wb_data1);
      exp_stall = instr_valid && !split && splits(instr0, instr1);
      if (fetch_stall !== exp_stall) begin
        $display("FAILED %0s: fetch_stall expected %0b, actual %0b",
                 row_name, exp_stall, fetch_stall);
        n_value++;
      end
      if (instr_valid && !fetch_stall) begin
        // a split instr0 went one edge earlier
        run_instr(instr0, split ? cycle + 1 : cycle + 2);
        run_instr(instr1, cycle + 2);
      end
      if (exp_stall) begin
        split = 1'b1;
      end else if (instr_valid) begin
        split = 1'b0;
      end
      cycle++;
      if (done && !done_seen) begin
        done_seen = 1'b1;
        if (exp_addr.size() != 0) begin
          $display("%0d expected write-backs never arrived", exp_addr.size());
          n_other++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module dual_issue_core (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      instr_valid,
  input  logic [31:0]               instr0,
  input  logic [31:0]               instr1,
  output logic                      fetch_stall,
  output logic                      wb_en0,
  output logic [`DI_REG_ADDR_W-1:0] wb_addr0,
  output logic [`DI_DATA_WIDTH-1:0] wb_data0,
  output logic                      wb_en1,
  output logic [`DI_REG_ADDR_W-1:0] wb_addr1,
  output logic [`DI_DATA_WIDTH-1:0] wb_data1
);

  lane_if lane_bus [`DI_NUM_LANES] ();

  issue_steer u_steer (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr0      (instr0),
    .instr1      (instr1),
    .fetch_stall (fetch_stall),
    .slot        (lane_bus)
  );

  for (genvar g = 0; g < `DI_NUM_LANES; g++) begin : g_lane
    exec_lane u_lane (
      .clk    (clk),
      .arst_n (arst_n),
      .lane   (lane_bus[g])
    );
  end

  register_file u_rf (
    .clk    (clk),
    .arst_n (arst_n),
    .lanes  (lane_bus)
  );

  // write-back out to the pins
  assign wb_en0   = lane_bus[0].wb_en;
  assign wb_addr0 = lane_bus[0].wb_addr;
  assign wb_data0 = lane_bus[0].wb_data;
  assign wb_en1   = lane_bus[1].wb_en;
  assign wb_addr1 = lane_bus[1].wb_addr;
  assign wb_data1 = lane_bus[1].wb_data;

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module register_file (
  input logic clk,
  input logic arst_n,
  lane_if.rf  lanes [`DI_NUM_LANES]
);

  logic [`DI_DATA_WIDTH-1:0]                     regs [`DI_NUM_REGS];
  logic [`DI_NUM_LANES-1:0]                      wb_en;
  logic [`DI_NUM_LANES-1:0][`DI_REG_ADDR_W-1:0]  wb_addr;
  logic [`DI_NUM_LANES-1:0][`DI_DATA_WIDTH-1:0]  wb_data;

  // pending writes win over storage, higher lane last
  function automatic logic [`DI_DATA_WIDTH-1:0] read_port(
    input logic [`DI_REG_ADDR_W-1:0]                    addr,
    input logic [`DI_NUM_LANES-1:0]                     en,
    input logic [`DI_NUM_LANES-1:0][`DI_REG_ADDR_W-1:0] waddr,
    input logic [`DI_NUM_LANES-1:0][`DI_DATA_WIDTH-1:0] wdata,
    input logic [`DI_DATA_WIDTH-1:0]                    stored
  );
    logic [`DI_DATA_WIDTH-1:0] val;
    val = stored;
    for (int i = 0; i < `DI_NUM_LANES; i++) begin
      if (en[i] && (waddr[i] == addr)) begin
        val = wdata[i];
      end
    end
    if (addr == '0) begin
      val = '0;
    end
    return val;
  endfunction

  for (genvar g = 0; g < `DI_NUM_LANES; g++) begin : g_port
    assign wb_en[g]   = lanes[g].wb_en;
    assign wb_addr[g] = lanes[g].wb_addr;
    assign wb_data[g] = lanes[g].wb_data;

    assign lanes[g].rs_data = read_port(lanes[g].rs_addr, wb_en, wb_addr, wb_data,
                                        regs[lanes[g].rs_addr]);
    assign lanes[g].rt_data = read_port(lanes[g].rt_addr, wb_en, wb_addr, wb_data,
                                        regs[lanes[g].rt_addr]);
  end

  // same destination in both lanes leaves lane 1's value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < `DI_NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int i = 0; i < `DI_NUM_LANES; i++) begin
        if (wb_en[i]) begin
          regs[wb_addr[i]] <= wb_data[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- exec_lane/exec_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module exec_lane (
  input logic clk,
  input logic arst_n,
  lane_if.lane lane
);

  dual_issue_pkg::ctrl_t     ctrl;
  logic [`DI_DATA_WIDTH-1:0] imm_ext;
  logic [`DI_DATA_WIDTH-1:0] operand_b;
  logic [`DI_DATA_WIDTH-1:0] alu_result;

  //////////////////////////////
  // decode and operands
  //////////////////////////////

  assign ctrl = dual_issue_pkg::decode(lane.instr);

  assign lane.rs_addr = lane.instr.r.rs;
  assign lane.rt_addr = lane.instr.r.rt;

  // immediates are zero extended
  assign imm_ext   = {{(`DI_DATA_WIDTH-`DI_IMM_WIDTH){1'b0}}, lane.instr.i.imm};
  assign operand_b = ctrl.alu_src ? imm_ext : lane.rt_data;

  lane_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (lane.rs_data),
    .b      (operand_b),
    .result (alu_result)
  );

  //////////////////////////////
  // result register
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane.wb_en <= 1'b0;
    end else begin
      // r0 writes never leave the lane
      lane.wb_en <= lane.issue_valid && ctrl.reg_write && (ctrl.dest != '0);
    end
  end

  always_ff @(posedge clk) begin
    lane.wb_addr <= ctrl.dest;
    lane.wb_data <= alu_result;
  end

endmodule

`default_nettype wire

//--- exec_lane/lane_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module lane_alu (
  input  dual_issue_pkg::alu_op_e    op,
  input  logic [`DI_DATA_WIDTH-1:0]  a,
  input  logic [`DI_DATA_WIDTH-1:0]  b,
  output logic [`DI_DATA_WIDTH-1:0]  result
);

  logic lt;

  // signed compare for slt
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      dual_issue_pkg::ALU_ADD: result = a + b;
      dual_issue_pkg::ALU_SUB: result = a - b;
      dual_issue_pkg::ALU_AND: result = a & b;
      dual_issue_pkg::ALU_OR:  result = a | b;
      dual_issue_pkg::ALU_XOR: result = a ^ b;
      dual_issue_pkg::ALU_SLT: result = {{(`DI_DATA_WIDTH-1){1'b0}}, lt};
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/issue_steer.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

module issue_steer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_valid,
  input  dual_issue_pkg::instr_u instr0,
  input  dual_issue_pkg::instr_u instr1,
  output logic                   fetch_stall,
  lane_if.steer                  slot [`DI_NUM_LANES]
);

  dual_issue_pkg::ctrl_t ctrl0;
  dual_issue_pkg::ctrl_t ctrl1;
  logic                  hit_rs;
  logic                  hit_rt;
  logic                  dep;
  logic                  split_q;

  //////////////////////////////
  // intra-pair dependency
  //////////////////////////////

  assign ctrl0 = dual_issue_pkg::decode(instr0);
  assign ctrl1 = dual_issue_pkg::decode(instr1);

  assign hit_rs = ctrl1.uses_rs && (instr1.r.rs == ctrl0.dest);
  assign hit_rt = ctrl1.uses_rt && (instr1.r.rt == ctrl0.dest);
  assign dep    = ctrl0.reg_write && (ctrl0.dest != '0) && (hit_rs || hit_rt);

  // only the first half of a pair can stall
  assign fetch_stall = instr_valid && !split_q && dep;

  //////////////////////////////
  // issue slots
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      split_q <= 1'b0;
      slot[0].issue_valid <= 1'b0;
      slot[1].issue_valid <= 1'b0;
    end else begin
      if (fetch_stall) begin
        split_q <= 1'b1;
      end else if (instr_valid) begin
        split_q <= 1'b0;
      end
      // lane 0 already went when split
      slot[0].issue_valid <= instr_valid && !split_q;
      // lane 1 waits out the stall
      slot[1].issue_valid <= instr_valid && !fetch_stall;
    end
  end

  always_ff @(posedge clk) begin
    slot[0].instr <= instr0;
    slot[1].instr <= instr1;
  end

endmodule

`default_nettype wire

//--- common/lane_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "dual_issue_macros.svh"

interface lane_if;
  // issue slot
  logic                      issue_valid;
  dual_issue_pkg::instr_u    instr;

  // operand read
  logic [`DI_REG_ADDR_W-1:0] rs_addr;
  logic [`DI_REG_ADDR_W-1:0] rt_addr;
  logic [`DI_DATA_WIDTH-1:0] rs_data;
  logic [`DI_DATA_WIDTH-1:0] rt_data;

  // write-back
  logic                      wb_en;
  logic [`DI_REG_ADDR_W-1:0] wb_addr;
  logic [`DI_DATA_WIDTH-1:0] wb_data;

  modport steer (output issue_valid, output instr);

  modport lane (
    input  issue_valid, instr, rs_data, rt_data,
    output rs_addr, rt_addr, wb_en, wb_addr, wb_data
  );

  modport rf (
    input  rs_addr, rt_addr, wb_en, wb_addr, wb_data,
    output rs_data, rt_data
  );
endinterface

`default_nettype wire

//--- common/dual_issue_pkg.sv
`default_nettype none

`include "dual_issue_macros.svh"

package dual_issue_pkg;

  typedef enum logic [5:0] {
    NOP  = 6'h00,
    ADD  = 6'h01,
    SUB  = 6'h02,
    AND  = 6'h03,
    OR   = 6'h04,
    XOR  = 6'h05,
    SLT  = 6'h06,
    ADDI = 6'h08,
    ORI  = 6'h0d
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  typedef struct packed {
    opcode_e                   opcode;
    logic [`DI_REG_ADDR_W-1:0] rs;
    logic [`DI_REG_ADDR_W-1:0] rt;
    logic [`DI_REG_ADDR_W-1:0] rd;
    logic [10:0]               tail;
  } r_fields_t;

  typedef struct packed {
    opcode_e                   opcode;
    logic [`DI_REG_ADDR_W-1:0] rs;
    logic [`DI_REG_ADDR_W-1:0] rt;
    logic [`DI_IMM_WIDTH-1:0]  imm;
  } i_fields_t;

  // same word, read as R or I type by opcode
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  typedef struct packed {
    alu_op_e                   alu_op;
    logic                      alu_src;
    logic                      reg_write;
    logic [`DI_REG_ADDR_W-1:0] dest;
    logic                      uses_rs;
    logic                      uses_rt;
  } ctrl_t;

  function automatic ctrl_t decode(instr_u ins);
    ctrl_t c;
    c = '0;
    case (ins.r.opcode)
      ADD, SUB, AND, OR, XOR, SLT: begin
        c.reg_write = 1'b1;
        c.dest = ins.r.rd;
        c.uses_rs = 1'b1;
        c.uses_rt = 1'b1;
      end
      ADDI, ORI: begin
        c.alu_src = 1'b1;
        c.reg_write = 1'b1;
        c.dest = ins.i.rt;
        c.uses_rs = 1'b1;
      end
      default: begin
        c.reg_write = 1'b0;
      end
    endcase
    // alu function
    case (ins.r.opcode)
      SUB: c.alu_op = ALU_SUB;
      AND: c.alu_op = ALU_AND;
      OR, ORI: c.alu_op = ALU_OR;
      XOR: c.alu_op = ALU_XOR;
      SLT: c.alu_op = ALU_SLT;
      default: c.alu_op = ALU_ADD;
    endcase
    return c;
  endfunction

endpackage

`default_nettype wire

//--- common/dual_issue_macros.svh
`ifndef DUAL_ISSUE_MACROS_SVH
`define DUAL_ISSUE_MACROS_SVH

// datapath widths
`define DI_DATA_WIDTH 32
`define DI_IMM_WIDTH 16

// register file
`define DI_NUM_REGS 32
`define DI_REG_ADDR_W 5

// two issue slots per cycle
`define DI_NUM_LANES 2

`endif
